// File: control.sv
`timescale 1ns/1ps

module control
	import decodePkg::*;
(
	input logic [4:0] opcode,
	input logic validIns,
	output logic regDst,
	output logic aluSrc,
	output logic [4:0] aluOp,
	output logic branch,
	output logic memRead,
	output logic memWrite,
	output logic jump,
	output logic memToReg,
	output logic regWrite,
	output logic halt,
	output logic zeroExt,
	output logic i1Fmt
);
	logic [4:0] newOpc;
	// bit order, msb first:
	// regDst aluSrc branch memRead memWrite jump memToReg regWrite halt zeroExt i1Fmt
	logic [10:0] ctl;

	// an empty slot decodes as nop so that nothing downstream fires
	assign newOpc = validIns ? opcode : opNop;
	assign aluOp = newOpc;

	assign {regDst, aluSrc, branch, memRead, memWrite, jump, memToReg, regWrite, halt,
		zeroExt, i1Fmt} = ctl;

	always_comb
	begin
		ctl = '0;
		case (newOpc) inside
			opHalt:
				ctl = 11'b0_0_0_0_0_0_0_0_1_0_0;
			// siic and rti are treated as plain nops here
			opNop, opSiic, opRti:
				ctl = 11'b0_0_0_0_0_0_0_0_0_0_0;
			// addi, subi and the four immediate shifts
			opI1, opI1 + 5'd1, [opShift : opShift + 5'd3]:
				ctl = 11'b0_1_0_0_0_0_0_1_0_0_1;
			// xori and andni take an unsigned immediate
			opI1 + 5'd2, opI1 + 5'd3:
				ctl = 11'b0_1_0_0_0_0_0_1_0_1_1;
			// st
			opLdSt:
				ctl = 11'b0_1_0_1_1_0_1_0_0_0_1;
			// ld
			opLdSt + 5'd1:
				ctl = 11'b0_1_0_1_1_0_1_1_0_0_1;
			// stu writes the updated base back
			opLdSt + 5'd3:
				ctl = 11'b0_1_0_1_1_0_0_1_0_0_1;
			[opR : 5'b11111]:
				ctl = 11'b1_0_0_0_0_0_0_1_0_0_0;
			// beqz, bnez, bltz, bgez
			[opI2 : opI2 + 5'd3]:
				ctl = 11'b0_1_1_0_0_0_0_0_0_0_0;
			opLbi:
				ctl = 11'b0_1_0_0_0_0_0_1_0_0_0;
			opSlbi:
				ctl = 11'b0_1_0_0_0_0_0_1_0_1_0;
			// j, jr, jal, jalr
			opJ:
				ctl = 11'b0_0_0_0_0_1_0_0_0_0_0;
			opJ + 5'd1:
				ctl = 11'b0_1_0_0_0_1_0_0_0_0_0;
			opJ + 5'd2:
				ctl = 11'b0_0_0_0_0_1_0_1_0_0_0;
			opJ + 5'd3:
				ctl = 11'b0_1_0_0_0_1_0_1_0_0_0;
		endcase
	end
endmodule

// File: decodeChecker.sv
`timescale 1ns/1ps

module decodeChecker
	import decodePkg::*;
(
	input logic clk,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [15:0] pwdata,
	input logic pready,
	input logic outValid,
	input logic outReady,
	input logic [15:0] outInsn,
	input logic [10:0] flags,
	input logic [4:0] aluOp,
	input logic [2:0] rsAddr,
	input logic [2:0] rtAddr,
	input logic [2:0] writeReg,
	input logic [15:0] imm,
	input logic halted,
	output int errCount,
	output int pending
);
	logic [15:0] expQ [$];
	insnWord_u w;

	// flag order: regDst aluSrc branch memRead memWrite jump memToReg regWrite halt zeroExt i1Fmt
	function automatic logic [10:0] predictFlags(input logic [4:0] op);
		int n;
		n = op;
		if ((n >= 8 && n <= 11) || (n >= 20 && n <= 23))
			return (n == 10 || n == 11) ? 11'b01000001011 : 11'b01000001001;
		if (n == 16)
			return 11'b01011010001;
		if (n == 17)
			return 11'b01011011001;
		if (n == 19)
			return 11'b01011001001;
		if (n >= 25)
			return 11'b10000001000;
		if (n >= 12 && n <= 15)
			return 11'b01100000000;
		if (n == 24)
			return 11'b01000001000;
		if (n == 18)
			return 11'b01000001010;
		if (n == 4)
			return 11'b00000100000;
		if (n == 5)
			return 11'b01000100000;
		if (n == 6)
			return 11'b00000101000;
		if (n == 7)
			return 11'b01000101000;
		if (n == 0)
			return 11'b00000000100;
		return 11'b0;
	endfunction

	task automatic checkOutput(input logic [15:0] word);
		logic [10:0] fl;
		logic [2:0] expWr;
		logic [15:0] expImm;
		w = word;
		fl = predictFlags(w.jFmt.opcode);
		if (fl[10])
			expWr = w.rFmt.rd;
		else if (fl[0])
			expWr = w.iFmt1.rd;
		else if (fl[5])
			expWr = linkReg;
		else
			expWr = w.iFmt2.rs;
		if (fl[0])
			expImm = fl[1] ? {11'b0, w.iFmt1.imm5} : {{11{w.iFmt1.imm5[4]}}, w.iFmt1.imm5};
		else if (fl[5])
			expImm = fl[1] ? {5'b0, w.jFmt.disp11} : {{5{w.jFmt.disp11[10]}}, w.jFmt.disp11};
		else
			expImm = fl[1] ? {8'b0, w.iFmt2.imm8} : {{8{w.iFmt2.imm8[7]}}, w.iFmt2.imm8};
		if (outInsn !== word || flags !== fl || aluOp !== w.jFmt.opcode)
		begin
			$display("** Error at %0t ns: word %h gave insn %h flags %b aluOp %h, expected flags %b",
				$time, word, outInsn, flags, aluOp, fl);
			errCount++;
		end
		if (rsAddr !== w.rFmt.rs || rtAddr !== w.rFmt.rt || writeReg !== expWr)
		begin
			$display("** Error at %0t ns: word %h gave rs %0d rt %0d wr %0d, expected %0d %0d %0d",
				$time, word, rsAddr, rtAddr, writeReg, w.rFmt.rs, w.rFmt.rt, expWr);
			errCount++;
		end
		if (imm !== expImm || halted !== fl[2])
		begin
			$display("** Error at %0t ns: word %h gave imm %h halted %b, expected %h %b",
				$time, word, imm, halted, expImm, fl[2]);
			errCount++;
		end
	endtask

	initial
	begin
		errCount = 0;
		pending = 0;
	end

	// results are compared when the consumer takes them
	always @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			expQ.delete();
		end
		else
		begin
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					$display("** Error at %0t ns: output %h appeared with no word written",
						$time, outInsn);
					errCount++;
				end
				else
				begin
					checkOutput(expQ.pop_front());
				end
			end
			if (psel && penable && pready && pwrite && paddr == regPush)
				expQ.push_back(pwdata);
		end
		pending = expQ.size();
	end
endmodule

// File: decodePkg.sv
package decodePkg;

	localparam int insnWidth = 16;
	localparam int apbAddrWidth = 8;

	// single opcodes, and the first code of each group with its members following in order
	localparam logic [4:0] opHalt = 5'b00000;
	localparam logic [4:0] opNop = 5'b00001;
	localparam logic [4:0] opSiic = 5'b00010;
	localparam logic [4:0] opRti = 5'b00011;
	localparam logic [4:0] opJ = 5'b00100;
	localparam logic [4:0] opI1 = 5'b01000;
	localparam logic [4:0] opI2 = 5'b01100;
	localparam logic [4:0] opLdSt = 5'b10000;
	localparam logic [4:0] opSlbi = 5'b10010;
	localparam logic [4:0] opShift = 5'b10100;
	localparam logic [4:0] opLbi = 5'b11000;
	localparam logic [4:0] opR = 5'b11001;

	// APB register map
	localparam logic [apbAddrWidth-1:0] regPush = 8'h00;
	localparam logic [apbAddrWidth-1:0] regStatus = 8'h04;
	localparam logic [apbAddrWidth-1:0] regResume = 8'h08;

	// jal and jalr write the return address here
	localparam logic [2:0] linkReg = 3'd7;

	// one instruction word seen through each of its encodings
	typedef union packed
	{
		struct packed
		{
			logic [4:0] opcode;
			logic [2:0] rs;
			logic [2:0] rd;
			logic [4:0] imm5;
		} iFmt1;
		struct packed
		{
			logic [4:0] opcode;
			logic [2:0] rs;
			logic [7:0] imm8;
		} iFmt2;
		struct packed
		{
			logic [4:0] opcode;
			logic [2:0] rs;
			logic [2:0] rt;
			logic [2:0] rd;
			logic [1:0] funct2;
		} rFmt;
		struct packed
		{
			logic [4:0] opcode;
			logic [10:0] disp11;
		} jFmt;
	} insnWord_u;

endpackage

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage
	import decodePkg::*;
#(
	parameter int insnWidth = 16
)
(
	input logic clk,
	input logic arstN,
	input logic resume,
	input logic outReady,
	insnQueueIf.sink popLink,
	output logic outValid,
	output logic [insnWidth-1:0] outInsn,
	output logic regDst,
	output logic aluSrc,
	output logic branch,
	output logic memRead,
	output logic memWrite,
	output logic jump,
	output logic memToReg,
	output logic regWrite,
	output logic halt,
	output logic zeroExt,
	output logic i1Fmt,
	output logic [4:0] aluOp,
	output logic [2:0] rsAddr,
	output logic [2:0] rtAddr,
	output logic [2:0] writeReg,
	output logic [insnWidth-1:0] imm,
	output logic halted
);
	insnWord_u word;
	logic take;
	logic nxtRegDst;
	logic nxtAluSrc;
	logic nxtBranch;
	logic nxtMemRead;
	logic nxtMemWrite;
	logic nxtJump;
	logic nxtMemToReg;
	logic nxtRegWrite;
	logic nxtHalt;
	logic nxtZeroExt;
	logic nxtI1Fmt;
	logic [4:0] nxtAluOp;
	logic [2:0] nxtWriteReg;
	logic [insnWidth-1:0] nxtImm;
	logic extBit;

	assign word = popLink.data;

	// pop only into an empty or draining output register, and never while halted
	assign popLink.ready = ~halted & (~outValid | outReady);
	assign take = popLink.valid & popLink.ready;

	control i_control
	(
		.opcode(word.jFmt.opcode),
		.validIns(popLink.valid),
		.regDst(nxtRegDst),
		.aluSrc(nxtAluSrc),
		.aluOp(nxtAluOp),
		.branch(nxtBranch),
		.memRead(nxtMemRead),
		.memWrite(nxtMemWrite),
		.jump(nxtJump),
		.memToReg(nxtMemToReg),
		.regWrite(nxtRegWrite),
		.halt(nxtHalt),
		.zeroExt(nxtZeroExt),
		.i1Fmt(nxtI1Fmt)
	);

	// destination register, highest priority first
	always_comb
	begin
		if (nxtRegDst)
			nxtWriteReg = word.rFmt.rd;
		else if (nxtI1Fmt)
			nxtWriteReg = word.iFmt1.rd;
		else if (nxtJump)
			nxtWriteReg = linkReg;
		else
			nxtWriteReg = word.iFmt2.rs;
	end

	// the fill bit is the field's sign bit unless the opcode asks for zero extension
	always_comb
	begin
		if (nxtI1Fmt)
		begin
			extBit = word.iFmt1.imm5[4] & ~nxtZeroExt;
			nxtImm = {{(insnWidth - 5){extBit}}, word.iFmt1.imm5};
		end
		else if (nxtJump)
		begin
			extBit = word.jFmt.disp11[10] & ~nxtZeroExt;
			nxtImm = {{(insnWidth - 11){extBit}}, word.jFmt.disp11};
		end
		else
		begin
			extBit = word.iFmt2.imm8[7] & ~nxtZeroExt;
			nxtImm = {{(insnWidth - 8){extBit}}, word.iFmt2.imm8};
		end
	end

	// result registers only load on a pop, so they hold under back-pressure
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			outInsn <= word;
			regDst <= nxtRegDst;
			aluSrc <= nxtAluSrc;
			branch <= nxtBranch;
			memRead <= nxtMemRead;
			memWrite <= nxtMemWrite;
			jump <= nxtJump;
			memToReg <= nxtMemToReg;
			regWrite <= nxtRegWrite;
			halt <= nxtHalt;
			zeroExt <= nxtZeroExt;
			i1Fmt <= nxtI1Fmt;
			aluOp <= nxtAluOp;
			rsAddr <= word.rFmt.rs;
			rtAddr <= word.rFmt.rt;
			writeReg <= nxtWriteReg;
			imm <= nxtImm;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			if (take)
				outValid <= 1'b1;
			else if (outReady)
				outValid <= 1'b0;
			// a halt word freezes the stage until the host writes resume
			if (take && nxtHalt)
				halted <= 1'b1;
			else if (resume)
				halted <= 1'b0;
		end
	end
endmodule

// File: decodeTb.sv
`timescale 1ns/1ps

module decodeTb
	import decodePkg::*;
();
	logic clk;
	logic arstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [15:0] pwdata;
	logic outReady;
	logic holdLow;
	wire [15:0] prdata;
	wire pready;
	wire pslverr;
	wire outValid;
	wire [15:0] outInsn;
	wire regDst;
	wire aluSrc;
	wire branch;
	wire memRead;
	wire memWrite;
	wire jump;
	wire memToReg;
	wire regWrite;
	wire halt;
	wire zeroExt;
	wire i1Fmt;
	wire halted;
	wire [4:0] aluOp;
	wire [2:0] rsAddr;
	wire [2:0] rtAddr;
	wire [2:0] writeReg;
	wire [15:0] imm;
	int errCount;
	int chkErrors;
	int pending;
	// stimulus table: APB address, write data, expected pslverr
	logic [7:0] tAddr [34];
	logic [15:0] tData [34];
	logic tErr [34];

	decodeTop #(.fifoDepth(4)) i_decodeTop (.*);

	decodeChecker i_decodeChecker
	(
		.clk(clk), .arstN(arstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pready(pready), .outValid(outValid),
		.outReady(outReady), .outInsn(outInsn),
		.flags({regDst, aluSrc, branch, memRead, memWrite, jump, memToReg, regWrite, halt,
			zeroExt, i1Fmt}),
		.aluOp(aluOp), .rsAddr(rsAddr), .rtAddr(rtAddr), .writeReg(writeReg), .imm(imm),
		.halted(halted), .errCount(chkErrors), .pending(pending)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	// random consumer stalls unless held off
	always @(negedge clk)
	begin
		outReady = holdLow ? 1'b0 : ($urandom % 4 != 0);
	end

	function automatic logic [15:0] buildWord(input logic [4:0] op, input logic [10:0] rest);
		insnWord_u w;
		w.jFmt.opcode = op;
		w.jFmt.disp11 = rest;
		return w;
	endfunction

	task automatic timeoutFail(input string msg);
		$display("Timeout: %s", msg);
		$display("Verification failed");
		$finish;
	endtask

	// pready is sampled in the low phase, where it already shows the coming edge
	task automatic apbAccess(input logic wr, input logic [7:0] addr, input logic [15:0] data,
		output logic [15:0] rdata, output logic err, output int waits);
		waits = 0;
		@(negedge clk);
		psel = 1'b1;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#5;
		while (!pready)
		begin
			waits++;
			if (waits > 200)
				timeoutFail("APB access never completed");
			@(negedge clk);
			#5;
		end
		err = pslverr;
		rdata = prdata;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic writeExpect(input logic [7:0] addr, input logic [15:0] data, input logic expErr,
		output int waits);
		logic [15:0] rd;
		logic err;
		apbAccess(1'b1, addr, data, rd, err, waits);
		if (err !== expErr)
		begin
			$display("** Error at %0t ns: write to %h gave pslverr %b, expected %b",
				$time, addr, err, expErr);
			errCount++;
		end
	endtask

	task automatic statusExpect(input logic [15:0] expStatus);
		logic [15:0] rd;
		logic err;
		int waits;
		apbAccess(1'b0, regStatus, 16'h0, rd, err, waits);
		if (rd !== expStatus || err !== 1'b0)
		begin
			$display("** Error at %0t ns: status %h pslverr %b, expected %h 0",
				$time, rd, err, expStatus);
			errCount++;
		end
	endtask

	task automatic waitDrain();
		int n;
		n = 0;
		while (pending != 0 || outValid)
		begin
			@(negedge clk);
			n++;
			if (n > 500)
				timeoutFail("decode output never drained");
		end
	endtask

	initial
	begin
		int waits;
		int totalWaits;
		int n;
		int svaFails;
		errCount = 0;
		void'($urandom(37349));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		holdLow = 1'b1;
		outReady = 1'b0;
		arstN = 1'b0;
		repeat (16) @(negedge clk);
		arstN = 1'b1;

		// odd opcodes get negative fields, even ones positive
		for (int i = 0; i < 31; i++)
		begin
			tAddr[i] = regPush;
			tData[i] = buildWord(5'(i + 1), (i % 2 == 0) ? 11'h4F9 : 11'h32A);
			tErr[i] = 1'b0;
		end
		// slbi once more, now with the top bit of imm8 set
		tAddr[31] = regPush;
		tData[31] = buildWord(opSlbi, 11'h4F9);
		tErr[31] = 1'b0;
		tAddr[32] = regStatus;
		tData[32] = 16'h1234;
		tErr[32] = 1'b1;
		tAddr[33] = 8'h1C;
		tData[33] = 16'h5678;
		tErr[33] = 1'b1;

		holdLow = 1'b0;
		for (int i = 0; i < 34; i++)
			writeExpect(tAddr[i], tData[i], tErr[i], waits);
		waitDrain();

		// overfill the queue with the consumer stopped, then release it
		holdLow = 1'b1;
		totalWaits = 0;
		fork
			begin
				for (int k = 0; k < 6; k++)
				begin
					writeExpect(regPush, buildWord(opR + 5'(k), 11'(k * 97 + 3)), 1'b0, waits);
					totalWaits += waits;
				end
			end
			begin
				repeat (30) @(negedge clk);
				holdLow = 1'b0;
			end
		join
		if (totalWaits == 0)
		begin
			$display("** Error at %0t ns: full queue produced no APB wait states", $time);
			errCount++;
		end
		waitDrain();

		// halt with two words behind it
		writeExpect(regPush, buildWord(opHalt, 11'h155), 1'b0, waits);
		writeExpect(regPush, buildWord(opLbi, 11'h2F0), 1'b0, waits);
		writeExpect(regPush, buildWord(opJ + 5'd2, 11'h7FF), 1'b0, waits);
		n = 0;
		while (!halted)
		begin
			@(negedge clk);
			n++;
			if (n > 100)
				timeoutFail("halted never rose");
		end
		repeat (5) @(negedge clk);
		statusExpect(16'h8002);
		writeExpect(regStatus, 16'h00FF, 1'b1, waits);
		writeExpect(8'h0C, 16'h00FF, 1'b1, waits);
		statusExpect(16'h8002);
		writeExpect(regResume, 16'h0001, 1'b0, waits);
		waitDrain();
		if (halted !== 1'b0)
		begin
			$display("** Error at %0t ns: halted still set after resume", $time);
			errCount++;
		end

		repeat (4) @(negedge clk);
		svaFails = i_decodeTop.i_decodeTopSva.failCount;
		$display("testbench errors %0d, checker errors %0d, assertion failures %0d",
			errCount, chkErrors, svaFails);
		if (errCount + chkErrors + svaFails == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end
endmodule

// File: decodeTop.sv
`timescale 1ns/1ps

module decodeTop
	import decodePkg::*;
#(
	parameter int fifoDepth = 4
)
(
	input logic clk,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apbAddrWidth-1:0] paddr,
	input logic [insnWidth-1:0] pwdata,
	output logic [insnWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic outValid,
	input logic outReady,
	output logic [insnWidth-1:0] outInsn,
	output logic regDst,
	output logic aluSrc,
	output logic branch,
	output logic memRead,
	output logic memWrite,
	output logic jump,
	output logic memToReg,
	output logic regWrite,
	output logic halt,
	output logic zeroExt,
	output logic i1Fmt,
	output logic [4:0] aluOp,
	output logic [2:0] rsAddr,
	output logic [2:0] rtAddr,
	output logic [2:0] writeReg,
	output logic [insnWidth-1:0] imm,
	output logic halted
);
	logic resume;

	// host to queue, then queue to decode
	insnQueueIf #(.depth(fifoDepth)) pushLink ();
	insnQueueIf #(.depth(fifoDepth)) popLink ();

	// the pop side carries the same fill level as the push side
	assign popLink.level = pushLink.level;

	insnApbSlave i_insnApbSlave (.*);

	insnFifo #(.depth(fifoDepth)) i_insnFifo (.*);

	decodeStage #(.insnWidth(insnWidth)) i_decodeStage (.*);
endmodule

// File: decodeTop_sva.sv
`timescale 1ns/1ps

module decodeTopSva
#(
	parameter int depth = 4
)
(
	input logic clk,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic outValid,
	input logic outReady,
	input logic [15:0] outInsn,
	input logic [15:0] imm,
	input logic [4:0] aluOp,
	input logic [2:0] writeReg,
	input logic halted,
	input logic [$clog2(depth + 1)-1:0] level
);
	int failCount;

	initial
	begin
		failCount = 0;
	end

	// an access phase is only stretched while the queue is full
	assert property (@(posedge clk) disable iff (!arstN)
		psel && penable && !pready |-> level == depth)
	else
	begin
		$error("APB wait state while the queue had room");
		failCount++;
	end

	// a stalled result must not move
	assert property (@(posedge clk) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable(outInsn) && $stable(imm)
		&& $stable(aluOp) && $stable(writeReg))
	else
	begin
		$error("decode output changed while stalled");
		failCount++;
	end

	// while halted the queue can only fill, never drain
	assert property (@(posedge clk) disable iff (!arstN) halted |=> level >= $past(level))
	else
	begin
		$error("queue popped while halted");
		failCount++;
	end
endmodule

bind decodeTop decodeTopSva #(.depth(fifoDepth)) i_decodeTopSva
(
	.clk(clk),
	.arstN(arstN),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.outValid(outValid),
	.outReady(outReady),
	.outInsn(outInsn),
	.imm(imm),
	.aluOp(aluOp),
	.writeReg(writeReg),
	.halted(halted),
	.level(popLink.level)
);

// File: insnApbSlave.sv
`timescale 1ns/1ps

module insnApbSlave
	import decodePkg::*;
(
	input logic clk,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apbAddrWidth-1:0] paddr,
	input logic [insnWidth-1:0] pwdata,
	input logic halted,
	output logic [insnWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic resume,
	insnQueueIf.src pushLink
);
	logic access;
	logic hitPush;
	logic hitStatus;
	logic hitResume;
	logic badAccess;

	assign access = psel & penable;
	assign hitPush = (paddr == regPush);
	assign hitStatus = (paddr == regStatus);
	assign hitResume = (paddr == regResume);

	// status is read only, and anything off the map is refused
	assign badAccess = ~(hitPush | hitStatus | hitResume) | (hitStatus & pwrite);

	// the word is offered for as long as the access phase lasts
	assign pushLink.valid = access & pwrite & hitPush;
	assign pushLink.data = pwdata;

	// a full queue stretches the access phase with wait states
	assign pready = access & (~pushLink.valid | pushLink.ready);
	assign pslverr = access & badAccess;

	always_comb
	begin
		prdata = '0;
		if (access && !pwrite && hitStatus)
		begin
			prdata = insnWidth'(pushLink.level);
			prdata[insnWidth-1] = halted;
		end
	end

	// resume follows the completed write by one cycle
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			resume <= 1'b0;
		end
		else
		begin
			resume <= access & pwrite & hitResume;
		end
	end
endmodule

// File: insnFifo.sv
`timescale 1ns/1ps

module insnFifo
	import decodePkg::*;
#(
	parameter int depth = 4
)
(
	input logic clk,
	input logic arstN,
	insnQueueIf.sink pushLink,
	insnQueueIf.src popLink
);
	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int levelWidth = $clog2(depth + 1);

	insnWord_u mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [levelWidth-1:0] level;
	logic doPush;
	logic doPop;

	// pointers wrap at depth, which need not be a power of two
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign doPush = pushLink.valid & pushLink.ready;
	assign doPop = popLink.valid & popLink.ready;

	assign pushLink.ready = (level != levelWidth'(depth));
	assign pushLink.level = level;

	// the head word is visible as soon as it is stored
	assign popLink.valid = (level != '0);
	assign popLink.data = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (doPush)
		begin
			mem[wrPtr] <= pushLink.data;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end
endmodule

// File: insnQueueIf.sv
`timescale 1ns/1ps

interface insnQueueIf
	import decodePkg::*;
#(
	parameter int depth = 4
);
	// a word moves on a rising clk edge when valid and ready are both high
	insnWord_u data;
	logic valid;
	logic ready;
	// words currently held by the buffer on this link
	logic [$clog2(depth + 1)-1:0] level;

	modport src
	(
		output data,
		output valid,
		input ready,
		input level
	);

	modport sink
	(
		input data,
		input valid,
		output ready,
		output level
	);
endinterface

// File: runSim.sh
#!/bin/sh
# build and run the decode front end testbench, then look for the pass line in the log
rm -f sim.log && \
verilator --binary --timing --assert -Wno-fatal --top-module decodeTb -f sim.f -o decodeSim && \
./obj_dir/decodeSim > sim.log 2>&1
cat sim.log
grep -q "^Verification passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim.f
decodePkg.sv
insnQueueIf.sv
insnApbSlave.sv
insnFifo.sv
control.sv
decodeStage.sv
decodeTop.sv
decodeTop_sva.sv
decodeChecker.sv
decodeTb.sv
